/* map_pkg.sv */
// Scroll map package
// Widths, fill limits and map word field positions shared by the tile front end
package map_pkg;

    localparam int MAP_AW   = 12;    // Map ROM address width
    localparam int MAP_DW   = 16;    // Map word width
    localparam int CACHE_AW = 5;     // Up to 32 cached columns
    localparam int SCR_HW   = 8;     // Pixel counter H width
    localparam int VPOS_W   = 12;    // Vertical map position, wraps at 4096
    localparam int VROW_W   = 4;     // Pixel row inside a 16x16 tile

    // Fill sweep over the column count
    localparam logic [8:0] H_START = 9'h100;
    localparam logic [8:0] H_END   = 9'h1F0;
    localparam logic [8:0] H_STEP  = 9'h010;   // One 16-pixel column

    // Map word fields
    localparam int CODE_W   = 11;    // Tile code in bits 10..0
    localparam int PAL_LSB  = 11;    // Palette in bits 14..11
    localparam int PAL_W    = 4;
    localparam int FLIP_BIT = 15;    // Horizontal flip

    typedef logic [MAP_DW-1:0] map_word_t;

    // Tile code, then row, then half-column select
    typedef logic [CODE_W+VROW_W:0] tile_addr_t;

    typedef logic [PAL_W-1:0] pal_t;

endpackage

/* dual_port_ram.sv */
// Two-port map word RAM
// One synchronous write port and one registered read port on the same clock
module dual_port_ram
    import map_pkg::*;
(
    input  logic                clk,
    input  map_word_t           wr_data,
    input  logic [CACHE_AW-1:0] wr_addr,
    input  logic                we,
    input  logic [CACHE_AW-1:0] rd_addr,
    output map_word_t           rd_data
);

    map_word_t mem [2**CACHE_AW];   // Row cache storage

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, one clock of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* map_cache.sv */
// Map row cache
// Fills 16 map words from ROM during blanking, serves them by H during the line
module map_cache
    import map_pkg::*;
(
    input  logic              rst,
    input  logic              clk,
    input  logic              pxl_cen,
    input  logic              LHBL,
    input  logic [SCR_HW-1:0] H,
    input  logic              row_start,
    input  logic              map_ok,
    input  map_word_t         map_data,
    output logic              map_cs,
    output logic              busy,
    output logic [8:0]        map_h,
    output logic              mapper_cen,
    output map_word_t         mapper_data
);

    typedef enum logic [1:0] {
        ST_REQ,      // Raise chip select
        ST_SETTLE,   // Map address settles, ROM sees the request
        ST_CHECK,    // Wait here for map_ok
        ST_ADDR      // Next column address settles
    } fill_st_t;

    fill_st_t            st;
    logic                last_rstart;   // row_start one clock back
    logic [8:0]          hcnt;          // Fill column count
    logic                fill_go;
    logic                map_we;
    logic [CACHE_AW-1:0] rd_addr;

    // Rising edge of row_start, only outside the active line
    assign fill_go = row_start && !last_rstart && !LHBL;

    // Word taken only when the check state sees the ROM answer
    assign map_we = busy && (st == ST_CHECK) && map_cs && map_ok;

    // H256 is always set on a 256-wide screen
    assign map_h      = busy ? hcnt : {1'b1, H};
    assign mapper_cen = busy ? 1'b1 : pxl_cen;   // Run the mapper flat out while filling
    assign rd_addr    = {1'b1, H[SCR_HW-1 -: CACHE_AW-1]};  // Same slot as hcnt[8:4]

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            map_cs      <= 1'b0;
            last_rstart <= 1'b0;
            hcnt        <= H_START;
            st          <= ST_REQ;
        end else begin
            last_rstart <= row_start;
            if (fill_go) begin
                busy <= 1'b1;
                hcnt <= H_START;
                st   <= ST_REQ;
            end else if (busy) begin
                case (st)
                    ST_REQ: begin
                        map_cs <= 1'b1;
                        st     <= ST_SETTLE;
                    end
                    ST_SETTLE: st <= ST_CHECK;
                    ST_CHECK: begin
                        if (map_ok) begin      // Otherwise stay and wait
                            map_cs <= 1'b0;
                            st     <= ST_ADDR;
                            if (hcnt == H_END) begin
                                busy <= 1'b0;   // Last column done
                            end else begin
                                hcnt <= hcnt + H_STEP;
                            end
                        end
                    end
                    ST_ADDR: st <= ST_REQ;
                    default: st <= ST_REQ;
                endcase
            end else begin
                map_cs <= 1'b1;   // Idle prefetch request
            end
        end
    end

    dual_port_ram u_cache (
        .clk     (clk),
        .wr_data (map_data),
        .wr_addr (hcnt[8:4]),
        .we      (map_we),
        .rd_addr (rd_addr),
        .rd_data (mapper_data)
    );

endmodule

/* map_addr_gen.sv */
// Map address generator
// Adds vertical scroll to the render line and forms the map ROM address
module map_addr_gen
    import map_pkg::*;
(
    input  logic              rst,
    input  logic              clk,
    input  logic [8:0]        map_h,
    input  logic [7:0]        vrender,
    input  logic [VPOS_W-1:0] scroll_y,
    output logic [MAP_AW-1:0] map_addr,
    output logic [VROW_W-1:0] vrow
);

    logic [VPOS_W-1:0] vpos;   // Vertical map position

    // Wraps at 4096 lines
    assign vpos = {{(VPOS_W-8){1'b0}}, vrender} + scroll_y;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_addr <= '0;
            vrow     <= '0;
        end else begin
            // Map row, then 16-pixel column
            map_addr <= {vpos[VPOS_W-1:VROW_W], map_h[7:4]};
            vrow     <= vpos[VROW_W-1:0];   // Pixel row inside the tile
        end
    end

endmodule

/* map_tile_decoder.sv */
// Map word decoder
// Splits a map word into palette, flip and the tile ROM address of the current row
module map_tile_decoder
    import map_pkg::*;
(
    input  logic              rst,
    input  logic              clk,
    input  logic              mapper_cen,
    input  map_word_t         mapper_data,
    input  logic [VROW_W-1:0] vrow,
    input  logic              hbit,
    output tile_addr_t        tile_addr,
    output pal_t              tile_pal,
    output logic              tile_hflip
);

    logic [CODE_W-1:0] code;
    logic              flip;
    logic              half;   // Half-column select after flip

    assign code = mapper_data[CODE_W-1:0];
    assign flip = mapper_data[FLIP_BIT];
    assign half = hbit ^ flip;   // Flipped tiles fetch the right half first

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_addr  <= '0;
            tile_pal   <= '0;
            tile_hflip <= 1'b0;
        end else if (mapper_cen) begin
            tile_addr  <= {code, vrow, half};
            tile_pal   <= mapper_data[PAL_LSB +: PAL_W];
            tile_hflip <= flip;   // Pixel order hint for the shifter
        end
    end

endmodule

/* scroll_map.sv */
// Scroll map front end
// Map address generator, row cache and tile decoder of one tile layer
module scroll_map
    import map_pkg::*;
(
    input  logic              rst,
    input  logic              clk,
    input  logic              pxl_cen,
    input  logic              LHBL,
    input  logic [SCR_HW-1:0] H,
    input  logic              row_start,
    input  logic [7:0]        vrender,
    input  logic [VPOS_W-1:0] scroll_y,
    input  logic              map_ok,
    input  map_word_t         map_data,
    output logic              map_cs,
    output logic [MAP_AW-1:0] map_addr,
    output logic              busy,
    output tile_addr_t        tile_addr,
    output pal_t              tile_pal,
    output logic              tile_hflip
);

    logic [8:0]        map_h;         // Fill count or H
    logic [VROW_W-1:0] vrow;
    logic              mapper_cen;
    map_word_t         mapper_data;   // Cached word for the current column

    map_addr_gen u_addr (
        .rst      (rst),
        .clk      (clk),
        .map_h    (map_h),
        .vrender  (vrender),
        .scroll_y (scroll_y),
        .map_addr (map_addr),
        .vrow     (vrow)
    );

    map_cache u_cache (
        .rst         (rst),
        .clk         (clk),
        .pxl_cen     (pxl_cen),
        .LHBL        (LHBL),
        .H           (H),
        .row_start   (row_start),
        .map_ok      (map_ok),
        .map_data    (map_data),
        .map_cs      (map_cs),
        .busy        (busy),
        .map_h       (map_h),
        .mapper_cen  (mapper_cen),
        .mapper_data (mapper_data)
    );

    map_tile_decoder u_dec (
        .rst         (rst),
        .clk         (clk),
        .mapper_cen  (mapper_cen),
        .mapper_data (mapper_data),
        .vrow        (vrow),
        .hbit        (H[3]),   // Left or right 8 pixels of the tile
        .tile_addr   (tile_addr),
        .tile_pal    (tile_pal),
        .tile_hflip  (tile_hflip)
    );

endmodule

/* tb_scroll_map.sv */
// Scroll map testbench
// Map ROM model, fills and active lines from the case file, checks of fill and tiles
module tb_scroll_map
    import map_pkg::*;
();

    logic              clk = 1'b0;
    logic              rst;
    logic              pxl_cen;
    logic              LHBL;
    logic [SCR_HW-1:0] H;
    logic              row_start;
    logic [7:0]        vrender;
    logic [VPOS_W-1:0] scroll_y;
    logic              map_ok;
    map_word_t         map_data;
    logic              map_cs;
    logic [MAP_AW-1:0] map_addr;
    logic              busy;
    tile_addr_t        tile_addr;
    pal_t              tile_pal;
    logic              tile_hflip;

    logic [15:0] case_mem [0:127];    // Count word, then 6 fields per case
    map_word_t   cache_words [16];    // Words the last fill should hold
    map_word_t   cur_base;            // ROM base of the running case
    int          cur_delay;
    int          wait_cnt;            // Cycles the current request has waited
    int          need;                // Wait needed before map_ok
    int          accepted;            // Words taken in the running fill
    int          errors;
    int          checks;
    bit          timed_out;
    bit          have_words;          // At least one fill done

    always #20 clk = ~clk;

    scroll_map dut (
        .rst        (rst),
        .clk        (clk),
        .pxl_cen    (pxl_cen),
        .LHBL       (LHBL),
        .H          (H),
        .row_start  (row_start),
        .vrender    (vrender),
        .scroll_y   (scroll_y),
        .map_ok     (map_ok),
        .map_data   (map_data),
        .map_cs     (map_cs),
        .map_addr   (map_addr),
        .busy       (busy),
        .tile_addr  (tile_addr),
        .tile_pal   (tile_pal),
        .tile_hflip (tile_hflip)
    );

    // ROM contents, base XOR address times a constant
    function automatic map_word_t rom_word(input logic [MAP_AW-1:0] addr);
        logic [15:0] prod;
        prod = {4'b0, addr} * 16'h9e37;   // Truncated to 16 bits
        return cur_base ^ prod;
    endfunction

    function automatic logic [VPOS_W-1:0] vpos_now();
        return scroll_y + {4'b0, vrender};   // Wraps at 4096
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input map_word_t got, input map_word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [MAP_AW-1:0] got, input logic [MAP_AW-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tile(input tile_addr_t got_addr, input pal_t got_pal,
                              input logic got_flip, input tile_addr_t exp_addr,
                              input pal_t exp_pal, input logic exp_flip, input string what);
        checks++;
        if (got_addr !== exp_addr || got_pal !== exp_pal || got_flip !== exp_flip) begin
            errors++;
            $display("mismatch at %0t: %s is %h/%h/%b, expected %h/%h/%b", $time, what,
                     got_addr, got_pal, got_flip, exp_addr, exp_pal, exp_flip);
        end
    endtask

    // ROM model, answers a fill request after the case delay plus a random stall
    initial begin
        void'($urandom(32'ha0e2_fc2a));   // Stall pattern fixed for the run
        forever begin
            @(posedge clk);
            #2;
            if (map_cs === 1'b1 && busy === 1'b1) begin
                if (wait_cnt >= need) begin
                    map_ok   = 1'b1;
                    map_data = rom_word(map_addr);
                end else begin
                    map_ok   = 1'b0;
                    wait_cnt = wait_cnt + 1;
                end
            end else begin
                wait_cnt = 0;
                need     = 2 + cur_delay + ($urandom % 3);   // Never before the check state
                map_ok   = (map_cs === 1'b0) && ($urandom % 4 == 0);  // Stray ok, no request
                map_data = $urandom;
            end
        end
    end

    // Accepted words, sampled mid cycle
    always @(negedge clk) begin
        logic [VPOS_W-1:0] v;
        logic [MAP_AW-1:0] a;
        if (busy === 1'b1 && map_cs === 1'b1 && map_ok === 1'b1) begin
            if (accepted >= 16) begin
                errors++;
                $display("error at %0t: a word was accepted after the 16th", $time);
            end else begin
                v = vpos_now();
                a = {v[VPOS_W-1:4], accepted[3:0]};   // Map row, then column
                check_addr(map_addr, a, $sformatf("fill address of column %0d", accepted));
                cache_words[accepted] = rom_word(a);
            end
            accepted++;
        end
    end

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (busy !== level) begin
            $display("timeout at %0t: busy did not go to %b %s", $time, level, what);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            check_flag(busy, 1'b0, "busy in reset");
            check_flag(map_cs, 1'b0, "map_cs in reset");
        end
        rst = 1'b0;
        @(negedge clk);             // Mid cycle, first clock out of reset still ahead
        check_flag(busy, 1'b0, "busy before first clock");
        check_flag(map_cs, 1'b0, "map_cs before first clock");
        next_cycle();
        check_flag(map_cs, 1'b1, "idle prefetch map_cs");
        check_flag(busy, 1'b0, "busy when idle");
    endtask

    task automatic run_fill();
        LHBL    = 1'b0;
        pxl_cen = 1'b0;
        next_cycle();               // row_start low for one clock first
        accepted  = 0;
        row_start = 1'b1;
        next_cycle();
        row_start = 1'b0;
        wait_busy(1'b1, 4, "after the row_start edge");
        if (!timed_out) begin
            wait_busy(1'b0, 2000, "at the end of the fill");
        end
        if (!timed_out && accepted != 16) begin
            errors++;
            $display("error at %0t: fill ended after %0d accepted words instead of 16",
                     $time, accepted);
        end
        have_words = 1'b1;
    endtask

    // No fill expected, cache keeps the previous row
    task automatic run_blank();
        LHBL      = 1'b1;
        row_start = 1'b1;           // Edge inside the active line
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            check_flag(busy, 1'b0, "busy after row_start with LHBL high");
        end
        LHBL = 1'b0;                // Blanking, row_start still held
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            check_flag(busy, 1'b0, "busy with row_start held high");
        end
        row_start = 1'b0;
    endtask

    task automatic run_line();
        map_word_t         w;
        tile_addr_t        exp_addr;
        logic [VPOS_W-1:0] v;
        logic [3:0]        row;
        v       = vpos_now();
        row     = v[3:0];
        LHBL    = 1'b1;
        pxl_cen = 1'b1;
        for (int h = 0; h < 256; h++) begin
            H = h[7:0];             // Held for two enables
            next_cycle();
            w = cache_words[h / 16];
            check_word(dut.mapper_data, w, $sformatf("cached word at H=%0d", h));
            next_cycle();
            exp_addr = {w[10:0], row, h[3] ^ w[15]};
            check_tile(tile_addr, tile_pal, tile_hflip, exp_addr, w[14:11], w[15],
                       $sformatf("tile at H=%0d", h));
        end
        pxl_cen = 1'b0;
    endtask

    initial begin
        int ncases;
        int base_i;
        int err_before;
        bit blank;
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        LHBL      = 1'b0;
        H         = '0;
        row_start = 1'b0;
        vrender   = '0;
        scroll_y  = '0;
        map_ok    = 1'b0;
        map_data  = '0;
        errors     = 0;
        checks     = 0;
        accepted   = 0;
        wait_cnt   = 0;
        need       = 2;
        cur_delay  = 0;
        cur_base   = '0;
        timed_out  = 1'b0;
        have_words = 1'b0;
        $readmemh("map_input.txt", case_mem);
        ncases = case_mem[0];
        if (ncases == 0) begin
            errors++;
            $display("error: no test cases could be read from map_input.txt");
        end
        apply_reset();
        for (int i = 0; i < ncases && !timed_out; i++) begin
            base_i     = 1 + 6 * i;
            err_before = errors;
            if (case_mem[base_i][0]) begin
                apply_reset();
            end
            scroll_y  = case_mem[base_i + 1][VPOS_W-1:0];
            vrender   = case_mem[base_i + 2][7:0];
            cur_delay = case_mem[base_i + 3];
            cur_base  = case_mem[base_i + 4];
            blank     = case_mem[base_i + 5][0];
            if (blank) begin
                run_blank();
            end else begin
                run_fill();
            end
            if (!timed_out && have_words) begin
                run_line();
            end
            $display("case %0d (%s): %0d errors", i, blank ? "blank" : "fill",
                     errors - err_before);
        end
        $display("%0d cases, %0d checks, %0d errors, timeout %0d", ncases, checks, errors,
                 timed_out);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* map_input.txt */
// Columns: reset scroll_y vrender ok_delay rom_base blank (1 = LHBL high at row_start)
// All values hex, the first word is the number of cases
13
1 000 00 0 0000 0
0 010 20 1 1234 0
0 000 20 0 5a5a 1
0 ff0 40 3 beef 0
0 123 7f 2 0f0f 0
0 456 80 0 ffff 1
1 800 ff 5 8001 0
0 abc 11 0 7777 0
0 fff 01 4 c3a5 1
0 200 e0 1 0000 0
0 7e5 3c 6 9999 0
0 001 00 2 4321 1
1 fa0 a5 0 aaaa 0
0 333 5c 3 1f2e 0
0 0a0 90 1 6b6b 0
0 5f5 0f 0 0101 1
0 e00 60 2 dead 0
1 100 33 0 f00d 0
0 3c3 c3 4 2468 0

/* compile.f */
map_pkg.sv
dual_port_ram.sv
map_cache.sv
map_addr_gen.sv
map_tile_decoder.sv
scroll_map.sv
tb_scroll_map.sv

/* Bender.yml */
package:
  name: scroll_map

dependencies: {}

sources:
  - map_pkg.sv
  - dual_port_ram.sv
  - map_cache.sv
  - map_addr_gen.sv
  - map_tile_decoder.sv
  - scroll_map.sv
  - target: simulation
    files:
      - tb_scroll_map.sv
